//--- hdl/ball_pkg.sv
package ball_pkg;

  // screen coordinate and ball timer value, 0 to 511
  typedef logic [8:0] pos_t;

  // ball is 2**BALL_SIZE_LOG pixels on a side
  localparam int BALL_SIZE_LOG = 2;

  // grid dots every 2**GRID_SHIFT pixels on both axes
  localparam int GRID_SHIFT = 3;

  // timebase bus shared by every block
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic display_on;
    // one cycle on the last pixel of a line
    logic line_end;
    // one cycle on the last pixel of the last line
    logic frame_end;
    pos_t hpos;
    pos_t vpos;
  } video_timing_t;

  // ball column and row windows for the current pixel
  typedef struct packed {
    logic hgfx;
    logic vgfx;
  } ball_gfx_t;

  // 3-bit pixel, b in the top bit
  typedef struct packed {
    logic b;
    logic g;
    logic r;
  } rgb_t;

  // sign of the per-frame step on one axis
  typedef enum logic {
    DIR_INC = 1'b0,
    DIR_DEC = 1'b1
  } dir_t;

endpackage

//--- hdl/video_timing.sv
`timescale 1ns/1ps

module video_timing
  import ball_pkg::*;
#(
  parameter int H_DISPLAY    = 256,
  parameter int H_TOTAL      = 309,
  parameter int H_SYNC_START = 280,
  parameter int H_SYNC_END   = 295,
  parameter int V_DISPLAY    = 240,
  parameter int V_TOTAL      = 262,
  parameter int V_SYNC_START = 251,
  parameter int V_SYNC_END   = 253
) (
  input  logic          ball_horiz_collide,
  input  logic          reset,
  output video_timing_t vt
);

  localparam pos_t H_LAST    = pos_t'(H_TOTAL - 1);
  localparam pos_t V_LAST    = pos_t'(V_TOTAL - 1);
  localparam pos_t H_DISP    = pos_t'(H_DISPLAY);
  localparam pos_t V_DISP    = pos_t'(V_DISPLAY);
  localparam pos_t H_SYNC_LO = pos_t'(H_SYNC_START);
  localparam pos_t H_SYNC_HI = pos_t'(H_SYNC_END);
  localparam pos_t V_SYNC_LO = pos_t'(V_SYNC_START);
  localparam pos_t V_SYNC_HI = pos_t'(V_SYNC_END);

  pos_t hpos;
  pos_t vpos;
  logic line_end;
  logic frame_end;

  // strobes come straight off the counters
  assign line_end  = (hpos == H_LAST);
  assign frame_end = line_end && (vpos == V_LAST);

  // pixel counter
  always_ff @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      hpos <= '0;
    end
    else if (line_end)
    begin
      hpos <= '0;
    end
    else
    begin
      hpos <= hpos + 9'd1;
    end
  end

  // line counter, steps once per line
  always_ff @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      vpos <= '0;
    end
    else if (frame_end)
    begin
      vpos <= '0;
    end
    else if (line_end)
    begin
      vpos <= vpos + 9'd1;
    end
  end

  // sync and display windows, same cycle as the counters
  always_comb
  begin
    vt.hsync      = (hpos >= H_SYNC_LO) && (hpos <= H_SYNC_HI);
    vt.vsync      = (vpos >= V_SYNC_LO) && (vpos <= V_SYNC_HI);
    vt.display_on = (hpos < H_DISP) && (vpos < V_DISP);
    vt.line_end   = line_end;
    vt.frame_end  = frame_end;
    vt.hpos       = hpos;
    vt.vpos       = vpos;
  end

endmodule

//--- hdl/ball_motion.sv
`timescale 1ns/1ps

module ball_motion
  import ball_pkg::*;
#(
  parameter int H_TOTAL    = 309,
  parameter int V_TOTAL    = 262,
  parameter int BALL_SPEED = 2
) (
  input  logic          ball_horiz_collide,
  input  logic          reset,
  input  video_timing_t vt,
  input  dir_t          h_dir,
  input  dir_t          v_dir,
  output ball_gfx_t     gfx
);

  // reload values give a timer period of exactly one line or one frame
  localparam pos_t H_STOP = pos_t'(513 - H_TOTAL);
  localparam pos_t V_STOP = pos_t'(513 - V_TOTAL);

  // starting phase puts the ball partway into the screen
  localparam pos_t H_RESET = pos_t'(513 - H_TOTAL - 128);
  localparam pos_t V_RESET = pos_t'(513 - V_TOTAL - 128);

  // ball window is the top few counts before the wrap
  localparam pos_t GFX_START = pos_t'(512 - (1 << BALL_SIZE_LOG));

  localparam pos_t SPEED = pos_t'(BALL_SPEED);

  pos_t h_timer;
  pos_t v_timer;
  pos_t h_move;
  pos_t v_move;
  logic h_wrap;
  logic v_wrap;

  assign h_wrap = (h_timer == '0);
  assign v_wrap = (v_timer == '0);

  // signed step as 9-bit two's complement
  always_comb
  begin
    if (h_dir == DIR_INC)
    begin
      h_move = SPEED;
    end
    else
    begin
      h_move = -SPEED;
    end

    if (v_dir == DIR_INC)
    begin
      v_move = SPEED;
    end
    else
    begin
      v_move = -SPEED;
    end
  end

  // horizontal timer slips only on the reload that falls in the v wrap line
  always_ff @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      h_timer <= H_RESET;
    end
    else if (h_wrap)
    begin
      if (v_wrap)
      begin
        h_timer <= H_STOP + h_move;
      end
      else
      begin
        h_timer <= H_STOP;
      end
    end
    else
    begin
      h_timer <= h_timer + 9'd1;
    end
  end

  // vertical timer counts lines and slips on every reload
  always_ff @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      v_timer <= V_RESET;
    end
    else if (vt.line_end)
    begin
      if (v_wrap)
      begin
        v_timer <= V_STOP + v_move;
      end
      else
      begin
        v_timer <= v_timer + 9'd1;
      end
    end
  end

  // windows line up with hpos and vpos of the same cycle
  always_comb
  begin
    gfx.hgfx = (h_timer >= GFX_START);
    gfx.vgfx = (v_timer >= GFX_START);
  end

endmodule

//--- hdl/bounce_control.sv
`timescale 1ns/1ps

module bounce_control
  import ball_pkg::*;
(
  input  logic          ball_horiz_collide,
  input  logic          reset,
  input  video_timing_t vt,
  input  ball_gfx_t     gfx,
  output dir_t          h_dir,
  output dir_t          v_dir
);

  pos_t h_last_vis;
  pos_t v_last_vis;
  pos_t v_last;
  logic limits_valid;
  logic h_collide;
  logic v_collide;
  logic h_collide_q;
  logic v_collide_q;

  // learn the screen edges from the timebase itself
  always_ff @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      h_last_vis   <= '0;
      v_last_vis   <= '0;
      v_last       <= '0;
      limits_valid <= 1'b0;
    end
    else
    begin
      if (vt.display_on)
      begin
        h_last_vis <= vt.hpos;
        // keep the lowest visible line seen so far
        if (vt.vpos > v_last_vis)
        begin
          v_last_vis <= vt.vpos;
        end
      end
      if (vt.frame_end)
      begin
        v_last       <= vt.vpos;
        limits_valid <= 1'b1;
      end
    end
  end

  // below the bottom edge or right of the display on line total-7
  assign v_collide = limits_valid && gfx.vgfx && (vt.vpos > v_last_vis);
  assign h_collide = limits_valid && gfx.hgfx && (vt.hpos > h_last_vis) &&
                     (vt.vpos == v_last - 9'd6);

  // flip on the first cycle of each collision
  always_ff @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      h_collide_q <= 1'b0;
      v_collide_q <= 1'b0;
      h_dir       <= DIR_DEC;
      v_dir       <= DIR_INC;
    end
    else
    begin
      h_collide_q <= h_collide;
      v_collide_q <= v_collide;
      if (h_collide && !h_collide_q)
      begin
        h_dir <= (h_dir == DIR_INC) ? DIR_DEC : DIR_INC;
      end
      if (v_collide && !v_collide_q)
      begin
        v_dir <= (v_dir == DIR_INC) ? DIR_DEC : DIR_INC;
      end
    end
  end

endmodule

//--- hdl/pixel_mixer.sv
`timescale 1ns/1ps

module pixel_mixer
  import ball_pkg::*;
(
  input  logic          ball_horiz_collide,
  input  logic          reset,
  input  video_timing_t vt,
  input  ball_gfx_t     gfx,
  output rgb_t          rgb
);

  logic grid;
  logic ball;
  rgb_t rgb_next;

  // one dot where both coordinates sit on the grid pitch
  assign grid = (vt.hpos[GRID_SHIFT-1:0] == '0) &&
                (vt.vpos[GRID_SHIFT-1:0] == '0);

  // ball square is the overlap of the two windows
  assign ball = gfx.hgfx && gfx.vgfx;

  always_comb
  begin
    rgb_next.r = vt.display_on && (gfx.hgfx || ball);
    rgb_next.g = vt.display_on && (grid || ball);
    rgb_next.b = vt.display_on && (gfx.vgfx || ball);
  end

  // output pixel lags the counters by one clock
  always_ff @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      rgb <= '0;
    end
    else
    begin
      rgb <= rgb_next;
    end
  end

endmodule

//--- hdl/ball_display_top.sv
`timescale 1ns/1ps

module ball_display_top
  import ball_pkg::*;
#(
  parameter int H_DISPLAY    = 256,
  parameter int H_TOTAL      = 309,
  parameter int H_SYNC_START = 280,
  parameter int H_SYNC_END   = 295,
  parameter int V_DISPLAY    = 240,
  parameter int V_TOTAL      = 262,
  parameter int V_SYNC_START = 251,
  parameter int V_SYNC_END   = 253,
  parameter int BALL_SPEED   = 2
) (
  input  logic ball_horiz_collide,
  input  logic reset,
  output logic hsync,
  output logic vsync,
  output rgb_t rgb
);

  video_timing_t vt;
  ball_gfx_t     gfx;
  dir_t          h_dir;
  dir_t          v_dir;

  video_timing #(
    .H_DISPLAY   (H_DISPLAY),
    .H_TOTAL     (H_TOTAL),
    .H_SYNC_START(H_SYNC_START),
    .H_SYNC_END  (H_SYNC_END),
    .V_DISPLAY   (V_DISPLAY),
    .V_TOTAL     (V_TOTAL),
    .V_SYNC_START(V_SYNC_START),
    .V_SYNC_END  (V_SYNC_END)
  ) timing_i (
    .ball_horiz_collide(ball_horiz_collide),
    .reset             (reset),
    .vt                (vt)
  );

  ball_motion #(
    .H_TOTAL   (H_TOTAL),
    .V_TOTAL   (V_TOTAL),
    .BALL_SPEED(BALL_SPEED)
  ) motion_i (
    .ball_horiz_collide(ball_horiz_collide),
    .reset             (reset),
    .vt                (vt),
    .h_dir             (h_dir),
    .v_dir             (v_dir),
    .gfx               (gfx)
  );

  bounce_control bounce_i (
    .ball_horiz_collide(ball_horiz_collide),
    .reset             (reset),
    .vt                (vt),
    .gfx               (gfx),
    .h_dir             (h_dir),
    .v_dir             (v_dir)
  );

  pixel_mixer mixer_i (
    .ball_horiz_collide(ball_horiz_collide),
    .reset             (reset),
    .vt                (vt),
    .gfx               (gfx),
    .rgb               (rgb)
  );

  // syncs are not delayed to match rgb
  assign hsync = vt.hsync;
  assign vsync = vt.vsync;

endmodule

//--- sim/tb_ball_display.sv
`timescale 1ns/1ps

module tb_ball_display
  import ball_pkg::*;
();

  localparam int H_DISPLAY    = 256;
  localparam int H_TOTAL      = 309;
  localparam int H_SYNC_START = 280;
  localparam int H_SYNC_END   = 295;
  localparam int V_DISPLAY    = 240;
  localparam int V_TOTAL      = 262;
  localparam int V_SYNC_START = 251;
  localparam int V_SYNC_END   = 253;
  localparam int BALL_SPEED   = 2;

  localparam pos_t H_LAST     = pos_t'(H_TOTAL - 1);
  localparam pos_t V_LAST     = pos_t'(V_TOTAL - 1);
  localparam pos_t H_DISP     = pos_t'(H_DISPLAY);
  localparam pos_t V_DISP     = pos_t'(V_DISPLAY);
  localparam pos_t V_LAST_VIS = pos_t'(V_DISPLAY - 1);
  localparam pos_t HS_LO      = pos_t'(H_SYNC_START);
  localparam pos_t HS_HI      = pos_t'(H_SYNC_END);
  localparam pos_t VS_LO      = pos_t'(V_SYNC_START);
  localparam pos_t VS_HI      = pos_t'(V_SYNC_END);
  localparam pos_t H_STOP     = pos_t'(513 - H_TOTAL);
  localparam pos_t V_STOP     = pos_t'(513 - V_TOTAL);
  localparam pos_t GFX_START  = pos_t'(512 - (1 << BALL_SIZE_LOG));
  localparam pos_t H_HIT_LINE = pos_t'(V_TOTAL - 7);
  localparam pos_t GRID_PITCH = pos_t'(1 << GRID_SHIFT);
  localparam pos_t SPEED      = pos_t'(BALL_SPEED);

  localparam int HS_WIDTH   = H_SYNC_END - H_SYNC_START + 1;
  localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;
  localparam int RUN_FRAMES = 10;
  // twelve frames of 40 ns pixels, plus reset and some slack
  localparam int TIMEOUT_NS = (12 * FRAME_CLKS + 105) * 40;

  logic ball_horiz_collide;
  logic reset;
  logic hsync;
  logic vsync;
  rgb_t rgb;

  // reference model state
  pos_t m_hpos;
  pos_t m_vpos;
  pos_t m_htimer;
  pos_t m_vtimer;
  dir_t m_hdir;
  dir_t m_vdir;
  logic m_hcol_q;
  logic m_vcol_q;
  logic m_line_end;
  logic m_frame_end;
  logic m_hgfx;
  logic m_vgfx;
  logic m_hcol;
  logic m_vcol;
  logic exp_hsync;
  logic exp_vsync;
  logic exp_disp;
  logic exp_grid;

  // model values of the pixel that rgb shows now
  logic p_disp;
  logic p_grid;
  logic p_hgfx;
  logic p_vgfx;
  pos_t p_hpos;
  pos_t p_vpos;

  logic hs_prev;
  logic hs_seen;
  int   hs_width;
  int   hs_gap;

  pos_t col_now;
  pos_t col_prev;
  logic col_found;
  logic col_prev_valid;
  int   frames_done;

  ball_display_top dut_i (
    .ball_horiz_collide(ball_horiz_collide),
    .reset             (reset),
    .hsync             (hsync),
    .vsync             (vsync),
    .rgb               (rgb)
  );

  always
  begin
    ball_horiz_collide = 1'b0;
    #20;
    ball_horiz_collide = 1'b1;
    #20;
  end

  task automatic report_and_stop(input string line);
    $display("%s", line);
    $display("Checks failed");
    $fatal(1);
  endtask

  // reload with the per-frame slip applied
  function automatic pos_t slipped_reload(input pos_t stop, input dir_t dir);
    if (dir == DIR_INC)
      return stop + SPEED;
    return stop - SPEED;
  endfunction

  assign m_line_end  = (m_hpos == H_LAST);
  assign m_frame_end = m_line_end && (m_vpos == V_LAST);
  assign exp_hsync   = (m_hpos >= HS_LO) && (m_hpos <= HS_HI);
  assign exp_vsync   = (m_vpos >= VS_LO) && (m_vpos <= VS_HI);
  assign exp_disp    = (m_hpos < H_DISP) && (m_vpos < V_DISP);
  assign exp_grid    = ((m_hpos % GRID_PITCH) == '0) && ((m_vpos % GRID_PITCH) == '0);
  assign m_hgfx      = (m_htimer >= GFX_START);
  assign m_vgfx      = (m_vtimer >= GFX_START);
  // bottom edge, and the right edge tested on one line only
  assign m_vcol      = m_vgfx && (m_vpos >= V_DISP);
  assign m_hcol      = m_hgfx && (m_hpos >= H_DISP) && (m_vpos == H_HIT_LINE);

  always @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      m_hpos   <= '0;
      m_vpos   <= '0;
      m_htimer <= H_STOP - 9'd128;
      m_vtimer <= V_STOP - 9'd128;
      m_hdir   <= DIR_DEC;
      m_vdir   <= DIR_INC;
      m_hcol_q <= 1'b0;
      m_vcol_q <= 1'b0;
    end
    else
    begin
      if (m_line_end)
      begin
        m_hpos <= '0;
        m_vpos <= m_frame_end ? '0 : m_vpos + 9'd1;
      end
      else
        m_hpos <= m_hpos + 9'd1;
      // horizontal timer only slips while the vertical one sits at zero
      if (m_htimer == '0)
        m_htimer <= (m_vtimer == '0) ? slipped_reload(H_STOP, m_hdir) : H_STOP;
      else
        m_htimer <= m_htimer + 9'd1;
      if (m_line_end)
        m_vtimer <= (m_vtimer == '0) ? slipped_reload(V_STOP, m_vdir) : m_vtimer + 9'd1;
      m_hcol_q <= m_hcol;
      m_vcol_q <= m_vcol;
      if (m_hcol && !m_hcol_q)
        m_hdir <= (m_hdir == DIR_INC) ? DIR_DEC : DIR_INC;
      if (m_vcol && !m_vcol_q)
        m_vdir <= (m_vdir == DIR_INC) ? DIR_DEC : DIR_INC;
    end
  end

  // rgb trails the counters by one clock
  always @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      p_disp <= 1'b0;
      p_grid <= 1'b0;
      p_hgfx <= 1'b0;
      p_vgfx <= 1'b0;
      p_hpos <= '0;
      p_vpos <= '0;
    end
    else
    begin
      p_disp <= exp_disp;
      p_grid <= exp_grid;
      p_hgfx <= m_hgfx;
      p_vgfx <= m_vgfx;
      p_hpos <= m_hpos;
      p_vpos <= m_vpos;
    end
  end

  // hsync width and rise spacing, measured on the port
  always @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      hs_prev  <= 1'b0;
      hs_seen  <= 1'b0;
      hs_width <= 0;
      hs_gap   <= 0;
    end
    else
    begin
      hs_prev  <= hsync;
      hs_width <= hsync ? hs_width + 1 : 0;
      if (hsync && !hs_prev)
      begin
        hs_gap  <= 1;
        hs_seen <= 1'b1;
      end
      else
        hs_gap <= hs_gap + 1;
    end
  end

  // ball column as drawn on the last visible line, once per frame
  always @(posedge ball_horiz_collide or posedge reset)
  begin
    if (reset)
    begin
      col_now        <= '0;
      col_prev       <= '0;
      col_found      <= 1'b0;
      col_prev_valid <= 1'b0;
      frames_done    <= 0;
    end
    else if (m_frame_end)
    begin
      col_prev       <= col_now;
      col_prev_valid <= col_found;
      col_found      <= 1'b0;
      frames_done    <= frames_done + 1;
    end
    else if ((p_vpos == V_LAST_VIS) && p_disp && rgb.r && !col_found)
    begin
      col_now   <= p_hpos;
      col_found <= 1'b1;
    end
  end

  a_hsync: assert property (@(posedge ball_horiz_collide) disable iff (reset)
    hsync == exp_hsync)
    else report_and_stop($sformatf("FAIL hsync expected %h got %h",
                                   $sampled(exp_hsync), $sampled(hsync)));

  a_vsync: assert property (@(posedge ball_horiz_collide) disable iff (reset)
    vsync == exp_vsync)
    else report_and_stop($sformatf("FAIL vsync expected %h got %h",
                                   $sampled(exp_vsync), $sampled(vsync)));

  a_hsync_period: assert property (@(posedge ball_horiz_collide) disable iff (reset)
    (hsync && !hs_prev && hs_seen) |-> (hs_gap == H_TOTAL))
    else report_and_stop($sformatf("FAIL hsync_period expected %h got %h",
                                   H_TOTAL, $sampled(hs_gap)));

  a_hsync_width: assert property (@(posedge ball_horiz_collide) disable iff (reset)
    (!hsync && hs_prev) |-> (hs_width == HS_WIDTH))
    else report_and_stop($sformatf("FAIL hsync_width expected %h got %h",
                                   HS_WIDTH, $sampled(hs_width)));

  a_blank: assert property (@(posedge ball_horiz_collide) disable iff (reset)
    !p_disp |-> (rgb == 3'h0))
    else report_and_stop($sformatf("FAIL rgb expected %h got %h", 3'h0, $sampled(rgb)));

  a_grid_on: assert property (@(posedge ball_horiz_collide) disable iff (reset)
    (p_disp && p_grid) |-> rgb.g)
    else report_and_stop($sformatf("FAIL rgb.g expected %h got %h", 1'b1, $sampled(rgb.g)));

  a_grid_off: assert property (@(posedge ball_horiz_collide) disable iff (reset)
    (p_disp && !p_grid && !(p_hgfx && p_vgfx)) |-> !rgb.g)
    else report_and_stop($sformatf("FAIL rgb.g expected %h got %h", 1'b0, $sampled(rgb.g)));

  a_red: assert property (@(posedge ball_horiz_collide) disable iff (reset)
    p_disp |-> (rgb.r == p_hgfx))
    else report_and_stop($sformatf("FAIL rgb.r expected %h got %h",
                                   $sampled(p_hgfx), $sampled(rgb.r)));

  a_blue: assert property (@(posedge ball_horiz_collide) disable iff (reset)
    p_disp |-> (rgb.b == p_vgfx))
    else report_and_stop($sformatf("FAIL rgb.b expected %h got %h",
                                   $sampled(p_vgfx), $sampled(rgb.b)));

  a_ball: assert property (@(posedge ball_horiz_collide) disable iff (reset)
    (p_disp && p_hgfx && p_vgfx) |-> (rgb == 3'h7))
    else report_and_stop($sformatf("FAIL rgb expected %h got %h", 3'h7, $sampled(rgb)));

  a_col_step: assert property (@(posedge ball_horiz_collide) disable iff (reset)
    (m_frame_end && col_found && col_prev_valid) |->
    (((col_now - col_prev) == SPEED) || ((col_prev - col_now) == SPEED)))
    else report_and_stop($sformatf("FAIL ball_column expected %h or %h got %h",
                                   $sampled(col_prev + SPEED), $sampled(col_prev - SPEED),
                                   $sampled(col_now)));

  initial
  begin
    reset <= 1'b1;
    repeat (5) @(posedge ball_horiz_collide);
    reset <= 1'b0;
    wait (frames_done == RUN_FRAMES);
    @(posedge ball_horiz_collide);
    $display("All checks passed");
    $finish;
  end

  initial
  begin
    #(TIMEOUT_NS);
    report_and_stop($sformatf("timeout: %0d frames did not complete in time", RUN_FRAMES));
  end

endmodule

//--- vlog.f
hdl/ball_pkg.sv
hdl/video_timing.sv
hdl/ball_motion.sv
hdl/bounce_control.sv
hdl/pixel_mixer.sv
hdl/ball_display_top.sv
sim/tb_ball_display.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_ball_display
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
